//--- aqp_sysctrl.f
+incdir+verilog
verilog/sysctrl_pkg.sv
verilog/bus_reset_sync.sv
verilog/hold_timer.sv
verilog/reset_sequencer.sv
verilog/phi_clock_gen.sv
verilog/aqp_sysctrl.sv
test/tb_aqp_sysctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the aqp_sysctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f aqp_sysctrl.f --top-module tb_aqp_sysctrl \
    --Mdir obj_dir -o tb_aqp_sysctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_aqp_sysctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF -- '*** FAILED ***' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

//--- test/tb_aqp_sysctrl.sv
`timescale 1ns/1ps
`include "sysctrl_defines.svh"

module tb_aqp_sysctrl;

    localparam int ext_hold    = `SYSCTRL_EXT_HOLD_CYCLES;
    localparam int int_hold    = `SYSCTRL_INT_HOLD_CYCLES;
    localparam int sync_stages = `SYSCTRL_SYNC_STAGES;
    localparam int clk_period  = 20;
    // per-wait bound, also one test's share of the watchdog
    localparam int wait_limit  = ext_hold + int_hold + 100;
    localparam int watchdog_cycles = 6 * wait_limit;

    logic sysclk;
    logic ext_reset_synced;
    logic reset_req;
    logic turbo_mode;
    logic ext_holder;
    wire  ebus_reset_sense;
    logic ebus_reset_drive;
    logic reset;
    logic ebus_phi;
    logic ebus_phi_clken;

    int error_count;
    int check_count;
    int test_count;

    // wired-and bus line, low if anyone pulls
    assign ebus_reset_sense = !(ebus_reset_drive || ext_holder);

    aqp_sysctrl uut (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .reset_req        (reset_req),
        .turbo_mode       (turbo_mode),
        .ebus_reset_sense (ebus_reset_sense),
        .ebus_reset_drive (ebus_reset_drive),
        .reset            (reset),
        .ebus_phi         (ebus_phi),
        .ebus_phi_clken   (ebus_phi_clken)
    );

    always #(clk_period / 2) sysclk = ~sysclk;

    // ******************************
    // checking helpers
    // ******************************
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR: %s", msg);
    endtask

    task automatic end_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - start_errors);
        end
    endtask

    // one-cycle request pulse
    task automatic pulse_reset_req;
        @(posedge sysclk);
        reset_req <= 1'b1;
        @(posedge sysclk);
        reset_req <= 1'b0;
    endtask

    // waits for the drive, counts its high samples, stops on first low one
    task automatic measure_drive(output int cycles);
        int guard;
        cycles = 0;
        guard = 0;
        @(negedge sysclk);
        while (!ebus_reset_drive && guard < wait_limit) begin
            guard++;
            @(negedge sysclk);
        end
        if (!ebus_reset_drive) begin
            report_problem("ebus_reset_drive never went high");
        end
        while (ebus_reset_drive && cycles < wait_limit) begin
            cycles++;
            // core held while the line is pulled
            check_value("reset", 32'(reset), 32'd1);
            @(negedge sysclk);
        end
    endtask

    // counts reset-high samples from the current one on
    task automatic measure_reset_tail(output int cycles);
        cycles = 0;
        while (reset && cycles < wait_limit) begin
            cycles++;
            check_value("ebus_reset_drive", 32'(ebus_reset_drive), 32'd0);
            @(negedge sysclk);
        end
        if (reset) begin
            report_problem("reset never fell after the bus line was released");
        end
    endtask

    task automatic check_tail(input int cycles);
        int ok;
        ok = (cycles >= int_hold && cycles <= sync_stages + int_hold + 4) ? 1 : 0;
        check_value($sformatf("reset tail of %0d cycles in range", cycles), ok, 1);
    endtask

    task automatic sync_to_clken;
        int guard;
        guard = 0;
        @(negedge sysclk);
        while (!ebus_phi_clken && guard < wait_limit) begin
            guard++;
            @(negedge sysclk);
        end
        if (!ebus_phi_clken) begin
            report_problem("no ebus_phi_clken pulse seen");
        end
    endtask

    // starts on a clken sample, ends on the next one
    task automatic measure_phi_period(input int period, input int high_len);
        int len;
        int high;
        logic prev_phi;
        len = 0;
        high = 0;
        prev_phi = 1'b0;
        do begin
            len++;
            high = high + (ebus_phi ? 1 : 0);
            prev_phi = ebus_phi;
            @(negedge sysclk);
        end while (!ebus_phi_clken && len < 4 * period);
        check_value("phi period", len, period);
        check_value("phi high cycles", high, high_len);
        // pulse sits in the first high cycle
        check_value("ebus_phi at clken", 32'(ebus_phi), 32'd1);
        check_value("ebus_phi before clken", 32'(prev_phi), 32'd0);
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic test_power_up;
        int start_errors;
        int n;
        start_errors = error_count;
        measure_drive(n);
        check_value("power-up drive cycles", n, ext_hold);
        measure_reset_tail(n);
        check_tail(n);
        end_test("power_up", start_errors);
    endtask

    task automatic test_req_in_run;
        int start_errors;
        int n;
        start_errors = error_count;
        pulse_reset_req();
        measure_drive(n);
        check_value("restart drive cycles", n, ext_hold);
        measure_reset_tail(n);
        check_tail(n);
        end_test("req_in_run", start_errors);
    endtask

    task automatic test_req_in_hold;
        int start_errors;
        int n;
        start_errors = error_count;
        pulse_reset_req();
        repeat (6) begin
            @(negedge sysclk);
            check_value("ebus_reset_drive mid hold", 32'(ebus_reset_drive), 32'd1);
        end
        // second request restarts the count
        pulse_reset_req();
        measure_drive(n);
        check_value("drive cycles after last request", n, ext_hold);
        measure_reset_tail(n);
        check_tail(n);
        end_test("req_in_hold", start_errors);
    endtask

    task automatic test_ext_holder;
        int start_errors;
        int n;
        int ok;
        start_errors = error_count;
        @(posedge sysclk);
        ext_holder <= 1'b1;
        n = 0;
        do begin
            @(negedge sysclk);
            n++;
            check_value("ebus_reset_drive", 32'(ebus_reset_drive), 32'd0);
        end while (!reset && n < wait_limit);
        ok = (reset && n <= sync_stages + 2) ? 1 : 0;
        check_value($sformatf("reset rise after %0d cycles in range", n), ok, 1);
        // holder keeps the core in reset
        repeat (30) begin
            @(negedge sysclk);
            check_value("reset while held", 32'(reset), 32'd1);
            check_value("ebus_reset_drive while held", 32'(ebus_reset_drive), 32'd0);
        end
        @(posedge sysclk);
        ext_holder <= 1'b0;
        @(negedge sysclk);
        measure_reset_tail(n);
        check_tail(n);
        end_test("ext_holder", start_errors);
    endtask

    task automatic test_phi_normal;
        int start_errors;
        start_errors = error_count;
        sync_to_clken();
        repeat (3) measure_phi_period(8, 4);
        end_test("phi_normal", start_errors);
    endtask

    task automatic test_phi_turbo;
        int start_errors;
        start_errors = error_count;
        @(posedge sysclk);
        turbo_mode <= 1'b1;
        // skip the period that holds the switch
        sync_to_clken();
        sync_to_clken();
        repeat (3) measure_phi_period(4, 2);
        @(posedge sysclk);
        turbo_mode <= 1'b0;
        sync_to_clken();
        sync_to_clken();
        repeat (2) measure_phi_period(8, 4);
        end_test("phi_turbo", start_errors);
    endtask

    // ******************************
    // main sequence and watchdog
    // ******************************
    initial begin
        sysclk = 1'b0;
        ext_reset_synced = 1'b1;
        reset_req = 1'b0;
        turbo_mode = 1'b0;
        ext_holder = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        repeat (4) @(posedge sysclk);
        // reset values
        @(negedge sysclk);
        check_value("ebus_reset_drive in reset", 32'(ebus_reset_drive), 32'd1);
        check_value("reset in reset", 32'(reset), 32'd1);
        check_value("ebus_phi in reset", 32'(ebus_phi), 32'd0);
        check_value("ebus_phi_clken in reset", 32'(ebus_phi_clken), 32'd0);
        @(posedge sysclk);
        ext_reset_synced <= 1'b0;
        test_power_up();
        test_req_in_run();
        test_req_in_hold();
        test_ext_holder();
        test_phi_normal();
        test_phi_turbo();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired, tests did not finish in %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verilog/aqp_sysctrl.sv
`timescale 1ns/1ps
`include "sysctrl_defines.svh"

module aqp_sysctrl
    import sysctrl_pkg::*;
(
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic reset_req,
    input  logic turbo_mode,
    // active low, read back from the wired bus line
    input  logic ebus_reset_sense,
    // high pulls the bus reset line low
    output logic ebus_reset_drive,
    output logic reset,
    output logic ebus_phi,
    output logic ebus_phi_clken
);

    // hold lengths in counter width
    localparam hold_cnt_t ext_hold_len = hold_cnt_t'(`SYSCTRL_EXT_HOLD_CYCLES);
    localparam hold_cnt_t int_hold_len = hold_cnt_t'(`SYSCTRL_INT_HOLD_CYCLES);

    logic bus_reset_seen;
    logic ext_timer_clear;
    logic int_timer_clear;
    logic ext_done;
    logic int_done;

    // ******************************
    // bus reset path
    // ******************************
    bus_reset_sync u_bus_reset_sync (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .ebus_reset_sense (ebus_reset_sense),
        .bus_reset_seen   (bus_reset_seen)
    );

    // length of the low pulse on the line
    hold_timer #(.length(ext_hold_len)) ext_hold_timer (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .clear            (ext_timer_clear),
        .done             (ext_done)
    );

    // internal reset tail after release
    hold_timer #(.length(int_hold_len)) int_hold_timer (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .clear            (int_timer_clear),
        .done             (int_done)
    );

    reset_sequencer u_reset_sequencer (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .reset_req        (reset_req),
        .bus_reset_seen   (bus_reset_seen),
        .ext_done         (ext_done),
        .int_done         (int_done),
        .ext_timer_clear  (ext_timer_clear),
        .int_timer_clear  (int_timer_clear),
        .ebus_reset_drive (ebus_reset_drive),
        .reset            (reset)
    );

    // ******************************
    // bus phi clock
    // ******************************
    phi_clock_gen u_phi_clock_gen (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .turbo_mode       (turbo_mode),
        .ebus_phi         (ebus_phi),
        .ebus_phi_clken   (ebus_phi_clken)
    );

endmodule

//--- verilog/phi_clock_gen.sv
`timescale 1ns/1ps
`include "sysctrl_defines.svh"

module phi_clock_gen
    import sysctrl_pkg::*;
(
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic turbo_mode,
    output logic ebus_phi,
    output logic ebus_phi_clken
);

    phi_div_t div;
    phi_div_t limit;

    // toggle point, turbo doubles phi
    assign limit = turbo_mode ? phi_div_t'(`SYSCTRL_PHI_LIMIT_TURBO)
                              : phi_div_t'(`SYSCTRL_PHI_LIMIT_NORMAL);

    // ******************************
    // divider and phi toggle
    // ******************************
    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            div            <= '0;
            ebus_phi       <= 1'b0;
            ebus_phi_clken <= 1'b0;
        end else if (div >= limit) begin
            // >= so a switch to turbo mid-count toggles right away
            div            <= '0;
            ebus_phi       <= ~ebus_phi;
            // pulse only on the rising toggle
            ebus_phi_clken <= ~ebus_phi;
        end else begin
            div            <= div + phi_div_t'(1);
            ebus_phi_clken <= 1'b0;
        end
    end

    // ******************************
    // checks
    // ******************************

    // enable sits in the first high cycle of phi
    a_clken_on_rise: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        ebus_phi_clken |-> (ebus_phi && !$past(ebus_phi))
    ) else $error("phi clken outside first high cycle of phi");

endmodule

//--- verilog/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer
    import sysctrl_pkg::*;
(
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic reset_req,
    input  logic bus_reset_seen,
    input  logic ext_done,
    input  logic int_done,
    output logic ext_timer_clear,
    output logic int_timer_clear,
    output logic ebus_reset_drive,
    output logic reset
);

    seq_state_t state;
    seq_state_t next_state;

    // ******************************
    // next state
    // ******************************
    always_comb begin
        next_state = state;
        case (state)
            st_ext_hold: begin
                // hold length reached, let go of the line
                if (ext_done) begin
                    next_state = st_wait_release;
                end
            end
            st_wait_release: begin
                // another device may still pull the line
                if (!bus_reset_seen) begin
                    next_state = st_int_hold;
                end
            end
            st_int_hold: begin
                // line pulled again during the tail
                if (bus_reset_seen) begin
                    next_state = st_wait_release;
                end else if (int_done) begin
                    next_state = st_run;
                end
            end
            st_run: begin
                // external holder on the bus
                if (bus_reset_seen) begin
                    next_state = st_wait_release;
                end
            end
            default: begin
                next_state = st_ext_hold;
            end
        endcase

        // request wins from any state, restarts the hold
        if (reset_req) begin
            next_state = st_ext_hold;
        end
    end

    // ******************************
    // timer control
    // ******************************

    // ext timer runs only in the hold, a request restarts it
    assign ext_timer_clear = (state != st_ext_hold) || reset_req;
    // int timer runs only in the tail
    assign int_timer_clear = (state != st_int_hold);

    // ******************************
    // state and outputs
    // ******************************
    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            state            <= st_ext_hold;
            ebus_reset_drive <= 1'b1;
            reset            <= 1'b1;
        end else begin
            state            <= next_state;
            // outputs follow the state they enter with
            ebus_reset_drive <= (next_state == st_ext_hold);
            reset            <= (next_state != st_run);
        end
    end

    // ******************************
    // checks
    // ******************************

    // the core is held whenever the bus is being reset
    a_drive_implies_reset: assert property (
        @(posedge sysclk) ebus_reset_drive |-> reset
    ) else $error("bus reset driven while internal reset low");

    // running means the line is released
    a_no_drive_in_run: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        (state == st_run) |-> !ebus_reset_drive
    ) else $error("bus reset driven in run state");

endmodule

//--- verilog/hold_timer.sv
`timescale 1ns/1ps

module hold_timer
    import sysctrl_pkg::*;
#(
    parameter hold_cnt_t length = hold_cnt_t'(16)
) (
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic clear,
    output logic done
);

    // count value in the final cycle of the hold
    // count is 0 in the first cycle after clear
    localparam hold_cnt_t last = length - hold_cnt_t'(1);

    hold_cnt_t count;

    // ******************************
    // saturating up-counter
    // ******************************
    always_ff @(posedge sysclk) begin
        if (ext_reset_synced || clear) begin
            count <= '0;
        end else if (count != last) begin
            count <= count + hold_cnt_t'(1);
        end
    end

    // high in the length-th cycle after clear and stays up
    assign done = (count == last);

    // ******************************
    // checks
    // ******************************

    // never runs past the end of the hold
    a_count_in_range: assert property (
        @(posedge sysclk) count <= last
    ) else $error("hold_timer count 0x%h past limit 0x%h", count, last);

endmodule

//--- verilog/bus_reset_sync.sv
`timescale 1ns/1ps
`include "sysctrl_defines.svh"

module bus_reset_sync (
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic ebus_reset_sense,
    output logic bus_reset_seen
);

    // sync chain, bit 0 samples the pad side
    logic [`SYSCTRL_SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            // preset to reset seen
            sync_q <= '1;
        end else begin
            // line is active low, chain carries active high
            sync_q <= {sync_q[`SYSCTRL_SYNC_STAGES-2:0], ~ebus_reset_sense};
        end
    end

    // last stage is the clean level
    assign bus_reset_seen = sync_q[`SYSCTRL_SYNC_STAGES-1];

endmodule

//--- verilog/sysctrl_pkg.sv
`include "sysctrl_defines.svh"

package sysctrl_pkg;

    // hold timer count
    typedef logic [`SYSCTRL_CNT_WIDTH-1:0] hold_cnt_t;

    // phi divider count, limits are 3 and 1
    typedef logic [1:0] phi_div_t;

    // ******************************
    // reset sequencer states
    // ******************************
    typedef enum logic [1:0] {
        // pulling the bus reset line low
        st_ext_hold     = 2'd0,
        // line still seen low, maybe by another device
        st_wait_release = 2'd1,
        // internal reset tail
        st_int_hold     = 2'd2,
        // normal operation
        st_run          = 2'd3
    } seq_state_t;

endpackage

//--- verilog/sysctrl_defines.svh
`ifndef SYSCTRL_DEFINES_SVH
`define SYSCTRL_DEFINES_SVH

// ******************************
// bus reset hold lengths
// ******************************

// 0 for the short simulation hold, 1 for the long hardware hold
`define SYSCTRL_SYNTH_HOLD 0

// short hold, in sysclk cycles
`define SYSCTRL_EXT_HOLD_SHORT 16
// long hold, roughly 140 ms at 35.8 MHz
`define SYSCTRL_EXT_HOLD_LONG 5000000

// cycles the bus reset line is driven low
`define SYSCTRL_EXT_HOLD_CYCLES \
    ((`SYSCTRL_SYNTH_HOLD != 0) ? `SYSCTRL_EXT_HOLD_LONG : `SYSCTRL_EXT_HOLD_SHORT)

// internal reset tail after the line is seen released
`define SYSCTRL_INT_HOLD_CYCLES 16

// hold counter width, must fit the long hold
`define SYSCTRL_CNT_WIDTH 24

// ******************************
// phi divider and sync depth
// ******************************
`define SYSCTRL_PHI_LIMIT_NORMAL 3
`define SYSCTRL_PHI_LIMIT_TURBO 1
`define SYSCTRL_SYNC_STAGES 2

`endif
